/* rtl/tcb_lite_pkg.sv */
// tcb-lite bus protocol parameters
// widths of the request and response fields and the response delay

package tcb_lite_pkg;

    ///////////////////////////////////////////////////////////////////////
    // request fields
    ///////////////////////////////////////////////////////////////////////

    // address width
    localparam int ADR = 32;
    // data width
    localparam int DAT = 32;
    // bytes per data word
    localparam int BYT = DAT/8;
    // logarithmic size field, 0/1/2 for 1/2/4 bytes
    localparam int SIZ = 2;

    ///////////////////////////////////////////////////////////////////////
    // response fields
    ///////////////////////////////////////////////////////////////////////

    // status field width
    localparam int STS = 2;
    // cycles from transfer to response
    localparam int DLY = 1;

endpackage

/* rtl/tcb_mem_pkg.sv */
// memory subordinate map and status encoding
// status codes returned with each response and the default depth

package tcb_mem_pkg;

    // access completed
    localparam logic [tcb_lite_pkg::STS-1:0] STS_OK = 2'd0;
    // address not a multiple of the transfer size
    localparam logic [tcb_lite_pkg::STS-1:0] STS_MISALIGN = 2'd1;
    // word address past the end of the memory
    localparam logic [tcb_lite_pkg::STS-1:0] STS_RANGE = 2'd2;

    ///////////////////////////////////////////////////////////////////////
    // memory map
    ///////////////////////////////////////////////////////////////////////

    // depth in words, power of two
    localparam int DEPTH_DEF = 256;

endpackage

/* rtl/tcb_lite_sub_ctl.sv */
`timescale 1ns/10ps
// tcb-lite subordinate controller
// handshake, access checks, memory strobes and the one-cycle response stage

module tcb_lite_sub_ctl #(
    parameter int DEPTH = tcb_mem_pkg::DEPTH_DEF
)(
    input  logic                                 man,
    input  logic                                 rst,
    // request from the manager
    input  logic                                 vld,
    input  logic                                 wen,
    input  logic [tcb_lite_pkg::SIZ-1:0]         siz,
    input  logic [tcb_lite_pkg::ADR-1:0]         adr,
    input  logic                                 ndn,
    output logic                                 rdy,
    // memory strobes
    output logic                                 mem_we,
    output logic                                 mem_re,
    output logic [$clog2(DEPTH)-1:0]             mem_adr,
    // response stage
    output logic                                 rsp_vld,
    output logic                                 err,
    output logic [tcb_lite_pkg::STS-1:0]         sts,
    output logic [$clog2(tcb_lite_pkg::BYT)-1:0] rsp_off,
    output logic [tcb_lite_pkg::SIZ-1:0]         rsp_siz,
    output logic                                 rsp_ndn,
    output logic                                 rsp_rd
);

    // byte offset bits within a word
    localparam int OFF = $clog2(tcb_lite_pkg::BYT);

    logic                         trn;
    logic                         mis;
    logic                         rng;
    logic [tcb_lite_pkg::STS-1:0] sts_nxt;

    ///////////////////////////////////////////////////////////////////////
    // request decode
    ///////////////////////////////////////////////////////////////////////

    assign trn = vld & rdy;

    // low address bits must be a multiple of the size
    always_comb begin
        case (siz)
            2'd0: mis = 1'b0;
            2'd1: mis = adr[0];
            2'd2: mis = |adr[OFF-1:0];
            // 8 byte transfers not supported
            default: mis = 1'b1;
        endcase
    end

    // word address past the memory
    assign rng = adr[tcb_lite_pkg::ADR-1:OFF] >= DEPTH;

    // misalignment wins over range
    assign sts_nxt = mis ? tcb_mem_pkg::STS_MISALIGN :
                     rng ? tcb_mem_pkg::STS_RANGE : tcb_mem_pkg::STS_OK;

    // strobes only for legal accesses
    assign mem_we  = trn &  wen & ~mis & ~rng;
    assign mem_re  = trn & ~wen & ~mis & ~rng;
    assign mem_adr = adr[OFF +: $clog2(DEPTH)];

    ///////////////////////////////////////////////////////////////////////
    // handshake and response stage
    ///////////////////////////////////////////////////////////////////////

    // ready rises one cycle after reset release
    always_ff @(posedge man) begin
        if (rst) begin
            rdy <= 1'b0;
        end else begin
            rdy <= 1'b1;
        end
    end

    // response flags, valid one cycle after trn
    always_ff @(posedge man) begin
        if (rst) begin
            rsp_vld <= 1'b0;
            err     <= 1'b0;
            sts     <= tcb_mem_pkg::STS_OK;
        end else begin
            rsp_vld <= trn;
            err     <= trn & (mis | rng);
            sts     <= trn ? sts_nxt : tcb_mem_pkg::STS_OK;
        end
    end

    // lane info for read alignment
    always_ff @(posedge man) begin
        if (trn) begin
            rsp_off <= adr[OFF-1:0];
            rsp_siz <= siz;
            rsp_ndn <= ndn;
            rsp_rd  <= ~wen;
        end
    end

endmodule

/* rtl/tcb_lite_wr_align.sv */
`timescale 1ns/10ps
// tcb-lite write alignment
// byte enables and lane placement of write data from size, offset and endianness

module tcb_lite_wr_align (
    input  logic [tcb_lite_pkg::SIZ-1:0]         siz,
    // byte offset within the word
    input  logic [$clog2(tcb_lite_pkg::BYT)-1:0] adr,
    input  logic                                 ndn,
    input  logic [tcb_lite_pkg::DAT-1:0]         wdt,
    output logic [tcb_lite_pkg::BYT-1:0]         ben,
    output logic [tcb_lite_pkg::DAT-1:0]         mem_wdt
);

    ///////////////////////////////////////////////////////////////////////
    // lane mapping
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        int unsigned len;
        int unsigned src;
        int unsigned lane;
        // transfer length in bytes, clamped to the bus width
        if (siz > 2) begin
            len = tcb_lite_pkg::BYT;
        end else begin
            len = 1 << siz;
        end
        ben     = '0;
        mem_wdt = '0;
        for (int unsigned i = 0; i < tcb_lite_pkg::BYT; i++) begin
            // big endian reverses bytes inside the transfer
            if (ndn) begin
                src = len - 1 - i;
            end else begin
                src = i;
            end
            lane = int'(adr) + i;
            // lanes past the word only on misaligned requests
            if ((i < len) && (lane < tcb_lite_pkg::BYT)) begin
                ben[lane]           = 1'b1;
                mem_wdt[8*lane +: 8] = wdt[8*src +: 8];
            end
        end
    end

endmodule

/* rtl/tcb_lite_rd_align.sv */
`timescale 1ns/10ps
// tcb-lite read alignment
// pulls the transfer bytes out of the memory word, reorders and zero-extends

module tcb_lite_rd_align (
    input  logic [tcb_lite_pkg::DAT-1:0]         mem_rdt,
    input  logic [$clog2(tcb_lite_pkg::BYT)-1:0] rsp_off,
    input  logic [tcb_lite_pkg::SIZ-1:0]         rsp_siz,
    input  logic                                 rsp_ndn,
    input  logic                                 rsp_rd,
    input  logic                                 err,
    output logic [tcb_lite_pkg::DAT-1:0]         rdt
);

    // inverse of the write lane mapping
    always_comb begin
        int unsigned len;
        int unsigned dst;
        int unsigned lane;
        if (rsp_siz > 2) begin
            len = tcb_lite_pkg::BYT;
        end else begin
            len = 1 << rsp_siz;
        end
        // upper bytes stay zero
        rdt = '0;
        for (int unsigned i = 0; i < tcb_lite_pkg::BYT; i++) begin
            if (rsp_ndn) begin
                dst = len - 1 - i;
            end else begin
                dst = i;
            end
            lane = int'(rsp_off) + i;
            // writes and failed accesses return zero
            if (rsp_rd && !err && (i < len) && (lane < tcb_lite_pkg::BYT)) begin
                rdt[8*dst +: 8] = mem_rdt[8*lane +: 8];
            end
        end
    end

endmodule

/* rtl/tcb_lite_sram.sv */
`timescale 1ns/10ps
// single port word memory
// byte lane write enables and a registered read port

module tcb_lite_sram #(
    parameter int DEPTH = tcb_mem_pkg::DEPTH_DEF
)(
    input  logic                         man,
    input  logic                         mem_we,
    input  logic                         mem_re,
    input  logic [$clog2(DEPTH)-1:0]     mem_adr,
    input  logic [tcb_lite_pkg::BYT-1:0] ben,
    input  logic [tcb_lite_pkg::DAT-1:0] mem_wdt,
    output logic [tcb_lite_pkg::DAT-1:0] mem_rdt
);

    // storage array
    logic [tcb_lite_pkg::DAT-1:0] mem [DEPTH];

    ///////////////////////////////////////////////////////////////////////
    // write and read ports
    ///////////////////////////////////////////////////////////////////////

    // byte lanes written only under the write strobe
    always_ff @(posedge man) begin
        if (mem_we) begin
            for (int b = 0; b < tcb_lite_pkg::BYT; b++) begin
                if (ben[b]) begin
                    mem[mem_adr][8*b +: 8] <= mem_wdt[8*b +: 8];
                end
            end
        end
    end

    // read register holds between reads
    always_ff @(posedge man) begin
        if (mem_re) begin
            mem_rdt <= mem[mem_adr];
        end
    end

endmodule

/* rtl/tcb_lite_mem_top.sv */
`timescale 1ns/10ps
// tcb-lite memory subordinate
// controller plus write alignment, word memory and read alignment

module tcb_lite_mem_top #(
    parameter int DEPTH = tcb_mem_pkg::DEPTH_DEF
)(
    input  logic                         man,
    input  logic                         rst,
    // request
    input  logic                         vld,
    input  logic                         wen,
    input  logic                         ndn,
    input  logic [tcb_lite_pkg::SIZ-1:0] siz,
    input  logic [tcb_lite_pkg::ADR-1:0] adr,
    input  logic [tcb_lite_pkg::DAT-1:0] wdt,
    output logic                         rdy,
    // response
    output logic                         rsp_vld,
    output logic [tcb_lite_pkg::DAT-1:0] rdt,
    output logic [tcb_lite_pkg::STS-1:0] sts,
    output logic                         err
);

    localparam int OFF = $clog2(tcb_lite_pkg::BYT);

    ///////////////////////////////////////////////////////////////////////
    // internal wiring
    ///////////////////////////////////////////////////////////////////////

    // memory port
    logic                         mem_we;
    logic                         mem_re;
    logic [$clog2(DEPTH)-1:0]     mem_adr;
    logic [tcb_lite_pkg::BYT-1:0] ben;
    logic [tcb_lite_pkg::DAT-1:0] mem_wdt;
    logic [tcb_lite_pkg::DAT-1:0] mem_rdt;
    // registered lane info
    logic [OFF-1:0]               rsp_off;
    logic [tcb_lite_pkg::SIZ-1:0] rsp_siz;
    logic                         rsp_ndn;
    logic                         rsp_rd;

    tcb_lite_sub_ctl #(
        .DEPTH (DEPTH)
    ) i_ctl (
        .man     (man),
        .rst     (rst),
        .vld     (vld),
        .wen     (wen),
        .siz     (siz),
        .adr     (adr),
        .ndn     (ndn),
        .rdy     (rdy),
        .mem_we  (mem_we),
        .mem_re  (mem_re),
        .mem_adr (mem_adr),
        .rsp_vld (rsp_vld),
        .err     (err),
        .sts     (sts),
        .rsp_off (rsp_off),
        .rsp_siz (rsp_siz),
        .rsp_ndn (rsp_ndn),
        .rsp_rd  (rsp_rd)
    );

    // live request lanes
    tcb_lite_wr_align i_wr_align (
        .siz     (siz),
        .adr     (adr[OFF-1:0]),
        .ndn     (ndn),
        .wdt     (wdt),
        .ben     (ben),
        .mem_wdt (mem_wdt)
    );

    tcb_lite_sram #(
        .DEPTH (DEPTH)
    ) i_sram (
        .man     (man),
        .mem_we  (mem_we),
        .mem_re  (mem_re),
        .mem_adr (mem_adr),
        .ben     (ben),
        .mem_wdt (mem_wdt),
        .mem_rdt (mem_rdt)
    );

    // response lanes, one cycle behind the request
    tcb_lite_rd_align i_rd_align (
        .mem_rdt (mem_rdt),
        .rsp_off (rsp_off),
        .rsp_siz (rsp_siz),
        .rsp_ndn (rsp_ndn),
        .rsp_rd  (rsp_rd),
        .err     (err),
        .rdt     (rdt)
    );

endmodule

/* sim/tcb_lite_mem_chk.sv */
`timescale 1ns/10ps
// response checker for the tcb-lite memory subordinate
// compares each response with the golden file and watches handshake timing

module tcb_lite_mem_chk (
    input  logic                         man,
    input  logic                         rst,
    input  logic                         vld,
    input  logic                         rdy,
    input  logic                         rsp_vld,
    input  logic [tcb_lite_pkg::DAT-1:0] rdt,
    input  logic [tcb_lite_pkg::STS-1:0] sts,
    input  logic                         err,
    // end of stimulus, check for missing responses
    input  logic                         fin,
    output int                           val_errs,
    output int                           prot_errs
);

    // fields per golden line
    localparam int FLD       = 9;
    localparam int MAX_LINES = 64;

    logic [31:0] gold [MAX_LINES*FLD];
    int          nlines;
    int          answered;
    // transfer seen at the previous edge
    logic        trn_prev;
    // reset seen at the previous edge, none before the first edge
    logic        rst_prev;

    // wen column is 0 or 1, anything else ends the list
    function automatic int count_lines();
        int n;
        n = 0;
        while ((n < MAX_LINES) && ((gold[n*FLD] === 32'h0) || (gold[n*FLD] === 32'h1))) begin
            n++;
        end
        return n;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            val_errs++;
        end
    endtask

    task automatic protocol_error(input string what);
        $display("at %0t: %s", $time, what);
        prot_errs++;
    endtask

    initial begin
        val_errs  = 0;
        prot_errs = 0;
        answered  = 0;
        trn_prev  = 1'b0;
        rst_prev  = 1'b0;
        $readmemh("sim/tcb_lite_mem_golden.txt", gold);
        nlines = count_lines();
    end

    ///////////////////////////////////////////////////////////////////////
    // per-cycle checks, sampled on the rising edge
    ///////////////////////////////////////////////////////////////////////

    always @(posedge man) begin
        if (rst) begin
            // sync reset only settles at the first reset edge
            if (rst_prev) begin
                if (rdy !== 1'b0) protocol_error("rdy is high during reset");
                if (rsp_vld !== 1'b0) protocol_error("response valid during reset");
            end
        end else begin
            // rdy still low in the first cycle out of reset
            if (rst_prev && (rdy !== 1'b0)) protocol_error("rdy is high right after reset");
            if (rsp_vld === 1'b1) begin
                if (!trn_prev) begin
                    protocol_error("response without a transfer one cycle earlier");
                end else if (answered >= nlines) begin
                    protocol_error("more responses than golden lines");
                end else begin
                    compare_field("rdt", gold[answered*FLD+5], rdt);
                    compare_field("sts", gold[answered*FLD+6], sts);
                    compare_field("err", gold[answered*FLD+7], err);
                    answered++;
                end
            end else if (trn_prev) begin
                protocol_error("no response one cycle after a transfer");
            end
        end
        trn_prev = !rst && (vld === 1'b1) && (rdy === 1'b1);
        rst_prev = rst;
    end

    // lines driven but never answered
    always @(posedge fin) begin
        if (answered < nlines) begin
            $display("%0d golden lines got no response", nlines - answered);
            prot_errs += nlines - answered;
        end
    end

endmodule

/* sim/tcb_lite_mem_tb.sv */
`timescale 1ns/10ps
// testbench for the tcb-lite memory subordinate
// clock, reset, golden-file manager driver and watchdog

module tcb_lite_mem_tb;

    localparam int FLD       = 9;
    localparam int MAX_LINES = 64;
    localparam int RST_CYC   = 4;
    localparam int PERIOD    = 40;

    logic                         man;
    logic                         rst;
    logic                         vld;
    logic                         wen;
    logic                         ndn;
    logic [tcb_lite_pkg::SIZ-1:0] siz;
    logic [tcb_lite_pkg::ADR-1:0] adr;
    logic [tcb_lite_pkg::DAT-1:0] wdt;
    logic                         rdy;
    logic                         rsp_vld;
    logic [tcb_lite_pkg::DAT-1:0] rdt;
    logic [tcb_lite_pkg::STS-1:0] sts;
    logic                         err;
    logic                         fin;
    int                           val_errs;
    int                           prot_errs;

    logic [31:0] gold [MAX_LINES*FLD];
    int          nlines;
    integer      seed;
    logic        loaded;

    always #(PERIOD/2) man = ~man;

    tcb_lite_mem_top #(
        .DEPTH (tcb_mem_pkg::DEPTH_DEF)
    ) i_dut (
        .man (man), .rst (rst), .vld (vld), .wen (wen), .ndn (ndn), .siz (siz),
        .adr (adr), .wdt (wdt), .rdy (rdy), .rsp_vld (rsp_vld), .rdt (rdt),
        .sts (sts), .err (err)
    );

    tcb_lite_mem_chk i_chk (
        .man (man), .rst (rst), .vld (vld), .rdy (rdy), .rsp_vld (rsp_vld),
        .rdt (rdt), .sts (sts), .err (err), .fin (fin),
        .val_errs (val_errs), .prot_errs (prot_errs)
    );

    function automatic int count_lines();
        int n;
        n = 0;
        while ((n < MAX_LINES) && ((gold[n*FLD] === 32'h0) || (gold[n*FLD] === 32'h1))) begin
            n++;
        end
        return n;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // manager driver, 2 ns after the edge
    ///////////////////////////////////////////////////////////////////////

    // request held until the edge where rdy is seen
    task automatic send_line(input int n);
        int idle;
        idle = 0;
        if (gold[n*FLD+8] != 0) idle = $unsigned($random(seed)) % 4;
        repeat (idle) begin
            @(posedge man);
            #2;
        end
        wen = gold[n*FLD][0];
        ndn = gold[n*FLD+1][0];
        siz = gold[n*FLD+2][tcb_lite_pkg::SIZ-1:0];
        adr = gold[n*FLD+3];
        wdt = gold[n*FLD+4];
        vld = 1'b1;
        @(posedge man);
        while (!rdy) @(posedge man);
        #2;
        vld = 1'b0;
    endtask

    initial begin
        man    = 1'b0;
        rst    = 1'b1;
        vld    = 1'b0;
        wen    = 1'b0;
        ndn    = 1'b0;
        siz    = '0;
        adr    = '0;
        wdt    = '0;
        fin    = 1'b0;
        seed   = 59;
        loaded = 1'b0;
        $readmemh("sim/tcb_lite_mem_golden.txt", gold);
        nlines = count_lines();
        loaded = 1'b1;
        if (nlines == 0) $display("golden file holds no transfers");
        repeat (RST_CYC) @(posedge man);
        #2;
        rst = 1'b0;
        for (int n = 0; n < nlines; n++) begin
            send_line(n);
        end
        // last response lands one cycle after its transfer
        repeat (tcb_lite_pkg::DLY + 1) @(posedge man);
        #2;
        fin = 1'b1;
        #1;
        $display("errors: %0d value, %0d protocol, over %0d transfers",
                 val_errs, prot_errs, nlines);
        if ((val_errs == 0) && (prot_errs == 0) && (nlines > 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // worst case of 3 idle and 2 handshake cycles per line
    initial begin
        int wd_ns;
        wait (loaded);
        wd_ns = (RST_CYC + nlines * (3 + 2) + 10) * PERIOD;
        #(wd_ns);
        $display("watchdog expired after %0d ns, run did not finish", wd_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tcb_lite_mem.f */
rtl/tcb_lite_pkg.sv
rtl/tcb_mem_pkg.sv
rtl/tcb_lite_sub_ctl.sv
rtl/tcb_lite_wr_align.sv
rtl/tcb_lite_rd_align.sv
rtl/tcb_lite_sram.sv
rtl/tcb_lite_mem_top.sv
sim/tcb_lite_mem_chk.sv
sim/tcb_lite_mem_tb.sv

/* sim/tcb_lite_mem_golden.txt */
// wen ndn siz adr wdt | expected rdt sts err | idle flag, all hex
// a wen value other than 0 or 1 ends the list
1 0 2 00000000 11223344 00000000 0 0 0
1 0 2 00000004 a5a55a5a 00000000 0 0 0
0 0 2 00000000 00000000 11223344 0 0 0
0 0 2 00000004 00000000 a5a55a5a 0 0 1
1 1 2 00000008 01020304 00000000 0 0 1
0 1 2 00000008 00000000 01020304 0 0 0
0 0 2 00000008 00000000 04030201 0 0 0
1 0 2 0000000c 00000000 00000000 0 0 1
1 0 0 0000000c 000000aa 00000000 0 0 0
1 0 0 0000000d 000000bb 00000000 0 0 0
1 0 0 0000000e 000000cc 00000000 0 0 1
1 0 0 0000000f ffffffdd 00000000 0 0 0
0 0 2 0000000c 00000000 ddccbbaa 0 0 0
1 0 1 00000000 0000beef 00000000 0 0 1
1 0 1 00000002 1234cafe 00000000 0 0 0
0 0 2 00000000 00000000 cafebeef 0 0 0
0 0 1 00000002 00000000 0000cafe 0 0 0
0 1 1 00000002 00000000 0000feca 0 0 1
0 0 0 0000000d 00000000 000000bb 0 0 0
1 1 1 00000004 00001234 00000000 0 0 0
0 0 2 00000004 00000000 a5a53412 0 0 0
1 0 2 00000001 deadbeef 00000000 1 1 1
0 0 1 00000003 00000000 00000000 1 1 0
1 0 2 00000400 deadbeef 00000000 2 1 0
0 0 0 000007ff 00000000 00000000 2 1 1
1 0 2 00000402 deadbeef 00000000 1 1 0
0 0 2 00000000 00000000 cafebeef 0 0 0
1 0 2 000003fc 0badf00d 00000000 0 0 1
0 0 2 000003fc 00000000 0badf00d 0 0 0
ff
